/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_ipu
RTL_TOP   := ipu_top
FILELIST  := project.f
BUILD_DIR := obj_dir
PASS_MSG  := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* logic/ipu.sv */
// Second IPU stage, spreads elements over four SIMD lanes and repacks their results
`timescale 1ns/1ps

module ipu (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       valid_i,
  input  ipu_pkg::op_e               op_i,
  input  ipu_pkg::vew_e              sew_i,
  input  logic [ipu_pkg::ELEN-1:0]   s1_i,
  input  logic [ipu_pkg::ELEN-1:0]   s2_i,
  input  logic [ipu_pkg::ELEN-1:0]   d_i,
  input  logic [ipu_pkg::ELENB-1:0]  carry_i,
  input  logic [ipu_pkg::ELENB-1:0]  be_i,
  output logic                       valid_o,
  output logic [ipu_pkg::ELEN-1:0]   result_o,
  output logic [ipu_pkg::ELEN-1:0]   d_o,
  output logic [ipu_pkg::ELENB-1:0]  be_o
);

  logic is_signed;
  // Sign extension enables for s1 and for s2/d
  logic ext1;
  logic ext2;

  // Lane operands, index 0 is s1, 1 is s2, 2 is d
  logic [2:0][7:0]  l8a_op;
  logic [2:0][7:0]  l8b_op;
  logic [2:0][15:0] l16_op;
  logic [2:0][31:0] l32_op;
  logic [3:0]       lane_carry;
  logic [3:0]       lane_valid;

  logic [7:0]  l8a_res;
  logic [7:0]  l8b_res;
  logic [15:0] l16_res;
  logic [31:0] l32_res;
  ipu_pkg::vew_e sew_q;

  assign is_signed = op_i inside {ipu_pkg::VMIN, ipu_pkg::VMAX, ipu_pkg::VMULH,
                                  ipu_pkg::VMULHSU};
  assign ext1 = is_signed && (op_i != ipu_pkg::VMULHSU);
  assign ext2 = is_signed;

  ////////////////////
  // Distributor
  ////////////////////

  // Lanes 0..3 are 8a, 8b, 16 and 32
  always_comb begin
    l8a_op     = '0;
    l8b_op     = '0;
    l16_op     = '0;
    l32_op     = '0;
    lane_carry = '0;
    lane_valid = '0;
    unique case (sew_i)
      ipu_pkg::EW_8: begin
        l8a_op[0] = s1_i[7:0];
        l8a_op[1] = s2_i[7:0];
        l8a_op[2] = d_i[7:0];
        l8b_op[0] = s1_i[15:8];
        l8b_op[1] = s2_i[15:8];
        l8b_op[2] = d_i[15:8];
        l16_op[0] = {{8{ext1 & s1_i[23]}}, s1_i[23:16]};
        l16_op[1] = {{8{ext2 & s2_i[23]}}, s2_i[23:16]};
        l16_op[2] = {{8{ext2 & d_i[23]}}, d_i[23:16]};
        l32_op[0] = {{24{ext1 & s1_i[31]}}, s1_i[31:24]};
        l32_op[1] = {{24{ext2 & s2_i[31]}}, s2_i[31:24]};
        l32_op[2] = {{24{ext2 & d_i[31]}}, d_i[31:24]};
        lane_carry = carry_i;
        lane_valid = {4{valid_i}};
      end
      ipu_pkg::EW_16: begin
        l16_op[0] = s1_i[15:0];
        l16_op[1] = s2_i[15:0];
        l16_op[2] = d_i[15:0];
        l32_op[0] = {{16{ext1 & s1_i[31]}}, s1_i[31:16]};
        l32_op[1] = {{16{ext2 & s2_i[31]}}, s2_i[31:16]};
        l32_op[2] = {{16{ext2 & d_i[31]}}, d_i[31:16]};
        lane_carry = {carry_i[1], carry_i[0], 2'b00};
        lane_valid = {valid_i, valid_i, 2'b00};
      end
      default: begin
        l32_op[0]  = s1_i;
        l32_op[1]  = s2_i;
        l32_op[2]  = d_i;
        lane_carry = {carry_i[0], 3'b000};
        lane_valid = {valid_i, 3'b000};
      end
    endcase
  end

  ////////////////////
  // SIMD lanes
  ////////////////////

  simd_lane #(.Width(8)) u_lane_8a (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (lane_valid[0]),
    .op_i        (op_i),
    .sew_i       (sew_i),
    .is_signed_i (is_signed),
    .s1_i        (l8a_op[0]),
    .s2_i        (l8a_op[1]),
    .d_i         (l8a_op[2]),
    .carry_i     (lane_carry[0]),
    .result_o    (l8a_res)
  );

  simd_lane #(.Width(8)) u_lane_8b (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (lane_valid[1]),
    .op_i        (op_i),
    .sew_i       (sew_i),
    .is_signed_i (is_signed),
    .s1_i        (l8b_op[0]),
    .s2_i        (l8b_op[1]),
    .d_i         (l8b_op[2]),
    .carry_i     (lane_carry[1]),
    .result_o    (l8b_res)
  );

  simd_lane #(.Width(16)) u_lane_16 (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (lane_valid[2]),
    .op_i        (op_i),
    .sew_i       (sew_i),
    .is_signed_i (is_signed),
    .s1_i        (l16_op[0]),
    .s2_i        (l16_op[1]),
    .d_i         (l16_op[2]),
    .carry_i     (lane_carry[2]),
    .result_o    (l16_res)
  );

  simd_lane #(.Width(32)) u_lane_32 (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (lane_valid[3]),
    .op_i        (op_i),
    .sew_i       (sew_i),
    .is_signed_i (is_signed),
    .s1_i        (l32_op[0]),
    .s2_i        (l32_op[1]),
    .d_i         (l32_op[2]),
    .carry_i     (lane_carry[3]),
    .result_o    (l32_res)
  );

  // Side registers, aligned with the lane result registers
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
      sew_q   <= ipu_pkg::EW_8;
      d_o     <= '0;
      be_o    <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        sew_q <= sew_i;
        d_o   <= d_i;
        be_o  <= be_i;
      end
    end
  end

  ////////////////////
  // Collector
  ////////////////////

  always_comb begin
    unique case (sew_q)
      ipu_pkg::EW_8:  result_o = {l32_res[7:0], l16_res[7:0], l8b_res, l8a_res};
      ipu_pkg::EW_16: result_o = {l32_res[15:0], l16_res};
      default:        result_o = l32_res;
    endcase
  end

endmodule

/* logic/ipu_merge_stage.sv */
// Last IPU stage, merges lane results into the old destination and drives the outputs
`timescale 1ns/1ps

module ipu_merge_stage (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       valid_i,
  input  logic [ipu_pkg::ELEN-1:0]   res_i,
  input  logic [ipu_pkg::ELEN-1:0]   d_i,
  input  logic [ipu_pkg::ELENB-1:0]  be_i,
  output logic                       valid_o,
  output logic [ipu_pkg::ELEN-1:0]   result_o,
  output logic [ipu_pkg::ELENB-1:0]  be_o
);

  logic [ipu_pkg::ELEN-1:0] merged;

  // Mask-undisturbed merge, disabled bytes keep the old destination
  always_comb begin
    for (int b = 0; b < ipu_pkg::ELENB; b++) begin
      merged[b*8 +: 8] = be_i[b] ? res_i[b*8 +: 8] : d_i[b*8 +: 8];
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  // be_o reads zero between results
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      be_o     <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o <= merged;
        be_o     <= be_i;
      end else begin
        be_o <= '0;
      end
    end
  end

endmodule

/* logic/ipu_operand_stage.sv */
// Issue register of the IPU pipeline, turns element masks into carries and byte enables
`timescale 1ns/1ps

module ipu_operand_stage (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       valid_i,
  input  ipu_pkg::op_e               op_i,
  input  ipu_pkg::vew_e              sew_i,
  input  logic [ipu_pkg::ELEN-1:0]   s1_i,
  input  logic [ipu_pkg::ELEN-1:0]   s2_i,
  input  logic [ipu_pkg::ELEN-1:0]   d_i,
  input  logic [ipu_pkg::ELENB-1:0]  mask_i,
  input  logic                       vm_i,
  output logic                       valid_o,
  output ipu_pkg::op_e               op_o,
  output ipu_pkg::vew_e              sew_o,
  output logic [ipu_pkg::ELEN-1:0]   s1_o,
  output logic [ipu_pkg::ELEN-1:0]   s2_o,
  output logic [ipu_pkg::ELEN-1:0]   d_o,
  output logic [ipu_pkg::ELENB-1:0]  carry_o,
  output logic [ipu_pkg::ELENB-1:0]  be_o
);

  // Mask bit per element, spread over the element's bytes
  logic [ipu_pkg::ELENB-1:0] elem_be;
  // Mask bit per element, placed at the element index
  logic [ipu_pkg::ELENB-1:0] elem_carry;
  logic [ipu_pkg::ELENB-1:0] carry_d;
  logic [ipu_pkg::ELENB-1:0] be_d;

  ////////////////////
  // Mask expansion
  ////////////////////

  // Mask bits of elements missing at this sew are dropped
  always_comb begin
    unique case (sew_i)
      ipu_pkg::EW_8: begin
        elem_be    = mask_i;
        elem_carry = mask_i;
      end
      ipu_pkg::EW_16: begin
        elem_be    = {{2{mask_i[1]}}, {2{mask_i[0]}}};
        elem_carry = ipu_pkg::ELENB'(mask_i[1:0]);
      end
      default: begin
        elem_be    = {ipu_pkg::ELENB{mask_i[0]}};
        elem_carry = ipu_pkg::ELENB'(mask_i[0]);
      end
    endcase
  end

  // VADC takes its carries from the mask and writes every byte
  always_comb begin
    if (op_i == ipu_pkg::VADC) begin
      carry_d = elem_carry;
      be_d    = '1;
    end else begin
      carry_d = '0;
      be_d    = vm_i ? '1 : elem_be;
    end
  end

  ////////////////////
  // Issue register
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
      op_o    <= ipu_pkg::VADD;
      sew_o   <= ipu_pkg::EW_8;
      s1_o    <= '0;
      s2_o    <= '0;
      d_o     <= '0;
      carry_o <= '0;
      be_o    <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        op_o    <= op_i;
        sew_o   <= sew_i;
        s1_o    <= s1_i;
        s2_o    <= s2_i;
        d_o     <= d_i;
        carry_o <= carry_d;
        be_o    <= be_d;
      end
    end
  end

endmodule

/* logic/ipu_pkg.sv */
// Shared word widths, opcode and element-width encodings, used by every SIMD IPU file
package ipu_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Operand word width in bits
  localparam int unsigned ELEN = 32;

  // Bytes per word, also the width of byte enables and carries
  localparam int unsigned ELENB = ELEN / 8;

  ////////////////////
  // Encodings
  ////////////////////

  // Integer SIMD operations
  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VADC,
    VAND,
    VOR,
    VXOR,
    VMIN,
    VMINU,
    VMAX,
    VMAXU,
    VMUL,
    VMULH,
    VMULHU,
    VMULHSU,
    VMACC
  } op_e;

  // Element width of one operation
  typedef enum logic [1:0] {
    EW_8,
    EW_16,
    EW_32
  } vew_e;

endpackage

/* logic/ipu_top.sv */
// Top level of the SIMD integer unit, chains operand, lane and merge stages
`timescale 1ns/1ps

module ipu_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       valid_i,
  input  ipu_pkg::op_e               op_i,
  input  ipu_pkg::vew_e              sew_i,
  input  logic [ipu_pkg::ELEN-1:0]   s1_i,
  input  logic [ipu_pkg::ELEN-1:0]   s2_i,
  input  logic [ipu_pkg::ELEN-1:0]   d_i,
  input  logic [ipu_pkg::ELENB-1:0]  mask_i,
  input  logic                       vm_i,
  output logic                       valid_o,
  output logic [ipu_pkg::ELEN-1:0]   result_o,
  output logic [ipu_pkg::ELENB-1:0]  be_o
);

  // Stage 1 to stage 2
  logic                      s1_valid;
  ipu_pkg::op_e              s1_op;
  ipu_pkg::vew_e             s1_sew;
  logic [ipu_pkg::ELEN-1:0]  s1_src1;
  logic [ipu_pkg::ELEN-1:0]  s1_src2;
  logic [ipu_pkg::ELEN-1:0]  s1_dst;
  logic [ipu_pkg::ELENB-1:0] s1_carry;
  logic [ipu_pkg::ELENB-1:0] s1_be;

  // Stage 2 to stage 3
  logic                      s2_valid;
  logic [ipu_pkg::ELEN-1:0]  s2_res;
  logic [ipu_pkg::ELEN-1:0]  s2_dst;
  logic [ipu_pkg::ELENB-1:0] s2_be;

  ipu_operand_stage u_operand_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .op_i     (op_i),
    .sew_i    (sew_i),
    .s1_i     (s1_i),
    .s2_i     (s2_i),
    .d_i      (d_i),
    .mask_i   (mask_i),
    .vm_i     (vm_i),
    .valid_o  (s1_valid),
    .op_o     (s1_op),
    .sew_o    (s1_sew),
    .s1_o     (s1_src1),
    .s2_o     (s1_src2),
    .d_o      (s1_dst),
    .carry_o  (s1_carry),
    .be_o     (s1_be)
  );

  ipu u_ipu (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (s1_valid),
    .op_i     (s1_op),
    .sew_i    (s1_sew),
    .s1_i     (s1_src1),
    .s2_i     (s1_src2),
    .d_i      (s1_dst),
    .carry_i  (s1_carry),
    .be_i     (s1_be),
    .valid_o  (s2_valid),
    .result_o (s2_res),
    .d_o      (s2_dst),
    .be_o     (s2_be)
  );

  ipu_merge_stage u_merge_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (s2_valid),
    .res_i    (s2_res),
    .d_i      (s2_dst),
    .be_i     (s2_be),
    .valid_o  (valid_o),
    .result_o (result_o),
    .be_o     (be_o)
  );

endmodule

/* logic/simd_lane.sv */
// One integer SIMD lane of configurable width, computes a single element and registers it
`timescale 1ns/1ps

module simd_lane #(
  parameter int unsigned Width = 32
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               valid_i,
  input  ipu_pkg::op_e       op_i,
  input  ipu_pkg::vew_e      sew_i,
  input  logic               is_signed_i,
  input  logic [Width-1:0]   s1_i,
  input  logic [Width-1:0]   s2_i,
  input  logic [Width-1:0]   d_i,
  input  logic               carry_i,
  output logic [Width-1:0]   result_o
);

  // Signedness of each multiplier operand
  logic s1_signed;
  logic s2_signed;

  logic [2*Width-1:0] s1_wide;
  logic [2*Width-1:0] s2_wide;
  logic [2*Width-1:0] product;
  // Element width in bits, used to pick the high product half
  logic [5:0]         ew_shift;
  logic [Width-1:0]   mul_high;
  logic               lt_signed;
  logic               lt_unsigned;
  logic [Width-1:0]   result_d;

  ////////////////////
  // Multiplier
  ////////////////////

  // VMULHSU has an unsigned s1 and a signed s2
  assign s1_signed = is_signed_i && (op_i != ipu_pkg::VMULHSU);
  assign s2_signed = is_signed_i;

  assign s1_wide = {{Width{s1_signed & s1_i[Width-1]}}, s1_i};
  assign s2_wide = {{Width{s2_signed & s2_i[Width-1]}}, s2_i};

  // Low 2*Width bits are right for both signed and unsigned inputs
  assign product = s1_wide * s2_wide;

  always_comb begin
    unique case (sew_i)
      ipu_pkg::EW_8:  ew_shift = 6'd8;
      ipu_pkg::EW_16: ew_shift = 6'd16;
      default:        ew_shift = 6'd32;
    endcase
  end

  // An 8b element in a wider lane keeps its high half at bits 15:8
  assign mul_high = Width'(product >> ew_shift);

  ////////////////////
  // Compare
  ////////////////////

  assign lt_signed   = $signed(s2_i) < $signed(s1_i);
  assign lt_unsigned = s2_i < s1_i;

  ////////////////////
  // Result select
  ////////////////////

  // Operand order follows RVV, e.g. VSUB is s2 - s1
  always_comb begin
    unique case (op_i)
      ipu_pkg::VADD:    result_d = s2_i + s1_i;
      ipu_pkg::VSUB:    result_d = s2_i - s1_i;
      ipu_pkg::VADC:    result_d = s2_i + s1_i + Width'(carry_i);
      ipu_pkg::VAND:    result_d = s2_i & s1_i;
      ipu_pkg::VOR:     result_d = s2_i | s1_i;
      ipu_pkg::VXOR:    result_d = s2_i ^ s1_i;
      ipu_pkg::VMIN:    result_d = lt_signed ? s2_i : s1_i;
      ipu_pkg::VMINU:   result_d = lt_unsigned ? s2_i : s1_i;
      ipu_pkg::VMAX:    result_d = lt_signed ? s1_i : s2_i;
      ipu_pkg::VMAXU:   result_d = lt_unsigned ? s1_i : s2_i;
      ipu_pkg::VMUL:    result_d = product[Width-1:0];
      ipu_pkg::VMULH,
      ipu_pkg::VMULHU,
      ipu_pkg::VMULHSU: result_d = mul_high;
      ipu_pkg::VMACC:   result_d = product[Width-1:0] + d_i;
      default:          result_d = '0;
    endcase
  end

  // Result register, loads only for active lanes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_o <= '0;
    end else if (valid_i) begin
      result_o <= result_d;
    end
  end

endmodule

/* project.f */
logic/ipu_pkg.sv
logic/ipu_operand_stage.sv
logic/simd_lane.sv
logic/ipu.sv
logic/ipu_merge_stage.sv
logic/ipu_top.sv
testbench/ipu_props.sv
testbench/tb_ipu.sv

/* testbench/ipu_props.sv */
// Concurrent checks on IPU pipeline timing and byte enables, bound to ipu_top
`timescale 1ns/1ps

module ipu_props (
  input logic                       clk_i,
  input logic                       arst_n_i,
  input logic                       valid_i,
  input logic                       valid_o,
  input logic [ipu_pkg::ELENB-1:0]  be_o
);

  // Three register stages between input and output valid
  a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o == $past(valid_i, 3))
    else $error("valid_o does not follow valid_i by three cycles");

  // No byte enables between results
  a_be_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !valid_o |-> (be_o == '0))
    else $error("be_o is not zero while valid_o is low");

  a_valid_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(valid_o))
    else $error("valid_o is unknown after reset");

endmodule

bind ipu_top ipu_props u_props (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .valid_i  (valid_i),
  .valid_o  (valid_o),
  .be_o     (be_o)
);

/* testbench/tb_ipu.sv */
// Random-stimulus testbench for ipu_top, checks every result against a reference model
`timescale 1ns/1ps

module tb_ipu;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_OPS    = 400;
  localparam int TIMEOUT_NS = (NUM_OPS * 2 + 50) * CLK_PERIOD;

  logic                      clk_i;
  logic                      arst_n_i;
  logic                      valid_i;
  ipu_pkg::op_e              op_i;
  ipu_pkg::vew_e             sew_i;
  logic [ipu_pkg::ELEN-1:0]  s1_i;
  logic [ipu_pkg::ELEN-1:0]  s2_i;
  logic [ipu_pkg::ELEN-1:0]  d_i;
  logic [ipu_pkg::ELENB-1:0] mask_i;
  logic                      vm_i;
  logic                      valid_o;
  logic [ipu_pkg::ELEN-1:0]  result_o;
  logic [ipu_pkg::ELENB-1:0] be_o;

  int seed;
  int checked;
  int data_errs;
  int timing_errs;

  // Scoreboard entry is {op, be, result}
  logic [39:0]   exp_q[$];
  logic [39:0]   exp_item;
  ipu_pkg::op_e  exp_op;
  // valid_i seen at the last three falling edges
  logic [2:0]    vhist;
  logic [31:0]   model_res;
  logic [3:0]    model_be;
  logic [31:0]   rnd_gap;

  ipu_top u_dut (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .op_i     (op_i),
    .sew_i    (sew_i),
    .s1_i     (s1_i),
    .s2_i     (s2_i),
    .d_i      (d_i),
    .mask_i   (mask_i),
    .vm_i     (vm_i),
    .valid_o  (valid_o),
    .result_o (result_o),
    .be_o     (be_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // One element of width ew, a is the s2 element and b the s1 element
  function automatic logic [31:0] elem_result(input ipu_pkg::op_e op, input int ew,
                                              input logic [31:0] a, input logic [31:0] b,
                                              input logic [31:0] dd, input logic cin);
    logic [31:0] em;
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] hi;
    logic [31:0] r;
    em = (32'h1 << ew) - 32'h1;
    ua = {32'h0, a & em};
    ub = {32'h0, b & em};
    sa = ua;
    sb = ub;
    if (a[ew-1]) sa = sa | {32'hffff_ffff, ~em};
    if (b[ew-1]) sb = sb | {32'hffff_ffff, ~em};
    hi = 64'h0;
    case (op)
      ipu_pkg::VADD:    r = a + b;
      ipu_pkg::VSUB:    r = a - b;
      ipu_pkg::VADC:    r = a + b + {31'b0, cin};
      ipu_pkg::VAND:    r = a & b;
      ipu_pkg::VOR:     r = a | b;
      ipu_pkg::VXOR:    r = a ^ b;
      ipu_pkg::VMIN:    r = ($signed(sa) < $signed(sb)) ? a : b;
      ipu_pkg::VMINU:   r = (ua < ub) ? a : b;
      ipu_pkg::VMAX:    r = ($signed(sa) < $signed(sb)) ? b : a;
      ipu_pkg::VMAXU:   r = (ua < ub) ? b : a;
      ipu_pkg::VMUL:    r = a * b;
      ipu_pkg::VMACC:   r = a * b + dd;
      ipu_pkg::VMULH:   hi = (sa * sb) >> ew;
      ipu_pkg::VMULHU:  hi = (ua * ub) >> ew;
      // Signed s2 times unsigned s1
      ipu_pkg::VMULHSU: hi = (sa * ub) >> ew;
      default:          r = 32'h0;
    endcase
    if (op inside {ipu_pkg::VMULH, ipu_pkg::VMULHU, ipu_pkg::VMULHSU}) r = hi[31:0];
    return r & em;
  endfunction

  // Whole word, with masking and the mask-undisturbed merge
  function automatic void word_result(input ipu_pkg::op_e op, input ipu_pkg::vew_e sew,
                                      input logic [31:0] s1, input logic [31:0] s2,
                                      input logic [31:0] d, input logic [3:0] mask,
                                      input logic vm, output logic [31:0] res,
                                      output logic [3:0] be);
    int ew;
    int bpe;
    logic [31:0] em;
    logic [31:0] raw;
    logic [31:0] er;
    ew  = (sew == ipu_pkg::EW_8) ? 8 : (sew == ipu_pkg::EW_16) ? 16 : 32;
    bpe = ew / 8;
    em  = (32'h1 << ew) - 32'h1;
    raw = 32'h0;
    be  = 4'h0;
    for (int k = 0; k < 32 / ew; k++) begin
      er  = elem_result(op, ew, (s2 >> (k * ew)) & em, (s1 >> (k * ew)) & em,
                        (d >> (k * ew)) & em, mask[k]);
      raw = raw | (er << (k * ew));
      for (int j = 0; j < bpe; j++) begin
        be[k*bpe+j] = (op == ipu_pkg::VADC) || vm || mask[k];
      end
    end
    for (int b = 0; b < 4; b++) begin
      res[b*8 +: 8] = be[b] ? raw[b*8 +: 8] : d[b*8 +: 8];
    end
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic drive_random_op();
    logic [31:0] rnd;
    rnd = $random(seed);
    op_i <= ipu_pkg::op_e'(4'(rnd % 32'd15));
    rnd = $random(seed);
    sew_i <= ipu_pkg::vew_e'(2'(rnd % 32'd3));
    s1_i <= $random(seed);
    s2_i <= $random(seed);
    d_i  <= $random(seed);
    rnd = $random(seed);
    mask_i  <= rnd[3:0];
    // Unmasked about one time in eight
    vm_i    <= (rnd[6:4] == 3'b000);
    valid_i <= 1'b1;
  endtask

  ////////////////////
  // Monitor and scoreboard
  ////////////////////

  // Outputs are sampled at the falling edge, away from the driving edge
  always @(negedge clk_i) begin
    assert (valid_o === vhist[2]) else begin
      timing_errs++;
      $display("error @ %0t: valid_o is %b, expected %b", $time, valid_o, vhist[2]);
    end
    if (valid_o === 1'b1) begin
      assert (exp_q.size() != 0) else begin
        timing_errs++;
        $display("An output appeared at %0t with no operation pending", $time);
      end
      if (exp_q.size() != 0) begin
        exp_item = exp_q.pop_front();
        exp_op   = ipu_pkg::op_e'(exp_item[39:36]);
        assert (result_o === exp_item[31:0]) else begin
          data_errs++;
          $display("error @ %0t: %s result %h, expected %h", $time, exp_op.name(),
                   result_o, exp_item[31:0]);
        end
        assert (be_o === exp_item[35:32]) else begin
          data_errs++;
          $display("error @ %0t: %s be_o %b, expected %b", $time, exp_op.name(),
                   be_o, exp_item[35:32]);
        end
        checked++;
      end
    end else begin
      assert (be_o === 4'h0) else begin
        data_errs++;
        $display("error @ %0t: be_o is %b while valid_o is low", $time, be_o);
      end
    end
    if (valid_i === 1'b1) begin
      word_result(op_i, sew_i, s1_i, s2_i, d_i, mask_i, vm_i, model_res, model_be);
      exp_q.push_back({op_i, model_be, model_res});
    end
    vhist = {vhist[1:0], valid_i};
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Errors found");
    $finish;
  end

  initial begin
    seed        = 57;
    checked     = 0;
    data_errs   = 0;
    timing_errs = 0;
    vhist       = 3'h0;
    arst_n_i    = 1'b0;
    valid_i     = 1'b0;
    op_i        = ipu_pkg::VADD;
    sew_i       = ipu_pkg::EW_8;
    s1_i        = '0;
    s2_i        = '0;
    d_i         = '0;
    mask_i      = '0;
    vm_i        = 1'b0;
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    // Mostly back-to-back, with a one-cycle gap now and then
    for (int i = 0; i < NUM_OPS; i++) begin
      @(posedge clk_i);
      drive_random_op();
      rnd_gap = $random(seed);
      if (rnd_gap[1:0] == 2'b00) begin
        @(posedge clk_i);
        valid_i <= 1'b0;
      end
    end
    @(posedge clk_i);
    valid_i <= 1'b0;
    wait (checked == NUM_OPS);
    // A few idle cycles to catch stray outputs
    repeat (4) @(posedge clk_i);
    $display("Summary: %0d ops checked, %0d data errors, %0d timing errors",
             checked, data_errs, timing_errs);
    if (data_errs + timing_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
